// File: caseIf.sv
// Sign and special-case flags passed from the case detector to the postprocessor
interface caseIf;

  // Divisor is zero
  logic divZero;
  // Signed minimum divided by minus one
  logic overflow;
  // Result signs
  logic negQuot;
  logic negRem;

  modport src (output divZero, overflow, negQuot, negRem);
  modport dst (input divZero, overflow, negQuot, negRem);

endinterface

// File: compile.f
+incdir+.
divTypesPkg.sv
divCtrlPkg.sv
srtIterIf.sv
caseIf.sv
srtPreproc.sv
srtIterate.sv
divSpecialCase.sv
srtPostproc.sv
srtCtrl.sv
divUnit.sv
tbDivUnit.sv

// File: divCtrlPkg.sv
// Control state encoding and fixed special-case results of the divider
package divCtrlPkg;

  // Handshake and sequencing states
  typedef enum logic [2:0] {
    IDLE,
    LOAD,
    ITER,
    POST,
    ACK
  } ctrlStateT;

  // Quotient returned on division by zero
  localparam divTypesPkg::dataT DIVZERO_QUOT = '1;

  // Most negative signed operand, also the overflow quotient
  localparam divTypesPkg::dataT SIGNED_MIN = {1'b1, {(divTypesPkg::XLEN - 1){1'b0}}};

endpackage

// File: divSpecialCase.sv
// Divide-by-zero, signed overflow and result sign detection
module divSpecialCase (
  input  divTypesPkg::dataT opA,
  input  divTypesPkg::dataT opB,
  input  logic              opSigned,
  caseIf.src                caseBus
);

  logic signA;
  logic signB;
  logic divByMinusOne;

  // Operand signs only count for signed requests
  assign signA = opSigned & opA[divTypesPkg::XLEN-1];
  assign signB = opSigned & opB[divTypesPkg::XLEN-1];

  assign divByMinusOne = (opB == '1);

  // Zero divisor for either signedness
  assign caseBus.divZero = (opB == '0);

  // Minimum over minus one has no positive counterpart
  assign caseBus.overflow = opSigned & divByMinusOne & (opA == divCtrlPkg::SIGNED_MIN);

  // Quotient truncates toward zero
  assign caseBus.negQuot = signA ^ signB;

  // Remainder follows the dividend
  assign caseBus.negRem = signA;

endmodule

// File: divTypesPkg.sv
// Shared data widths and vector types for the SRT divider datapath
package divTypesPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  // Operand and result width
  localparam int XLEN = 32;

  // Carry-save word: sign plus three integer bits above the fraction
  localparam int WLEN = XLEN + 4;

  // Leading-zero and iteration counts reach XLEN + 1
  localparam int LZW = 6;

  ////////////////////////////////////////////////////////////////////////////
  // Vector types
  ////////////////////////////////////////////////////////////////////////////

  // Dividend, divisor, quotient or remainder
  typedef logic [XLEN-1:0] dataT;

  // Partial remainder halves and the normalized divisor
  typedef logic [WLEN-1:0] wordT;

  // Leading-zero count, shift amount or iteration count
  typedef logic [LZW-1:0] lzT;

endpackage

// File: divUnit.sv
// Top of the SRT integer divider with a four-phase req/ack port
module divUnit (
  input  logic              clk,
  input  logic              arstN,
  input  logic              req,
  output logic              ack,
  input  divTypesPkg::dataT dividend,
  input  divTypesPkg::dataT divisor,
  input  logic              isSigned,
  output divTypesPkg::dataT quotient,
  output divTypesPkg::dataT remainder
);

  divTypesPkg::dataT opA;
  divTypesPkg::dataT opB;
  logic              opSigned;
  logic              finish;

  srtIterIf iterBus ();
  caseIf    caseBus ();

  ////////////////////////////////////////////////////////////////////////////
  // Sequencing and operand capture
  ////////////////////////////////////////////////////////////////////////////

  srtCtrl uCtrl (
    .clk      (clk),
    .arstN    (arstN),
    .req      (req),
    .ack      (ack),
    .dividend (dividend),
    .divisor  (divisor),
    .isSigned (isSigned),
    .opA      (opA),
    .opB      (opB),
    .opSigned (opSigned),
    .finish   (finish),
    .iterBus  (iterBus.ctrl)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Recurrence path and special-case path side by side
  ////////////////////////////////////////////////////////////////////////////

  srtPreproc uPreproc (.opA(opA), .opB(opB), .opSigned(opSigned), .iterBus(iterBus.pre));

  srtIterate uIterate (
    .clk     (clk),
    .arstN   (arstN),
    .start   (iterBus.start),
    .iterBus (iterBus.iter)
  );

  divSpecialCase uCase (.opA(opA), .opB(opB), .opSigned(opSigned), .caseBus(caseBus.src));

  srtPostproc uPostproc (
    .clk       (clk),
    .arstN     (arstN),
    .finish    (finish),
    .opA       (opA),
    .iterBus   (iterBus.post),
    .caseBus   (caseBus.dst),
    .quotient  (quotient),
    .remainder (remainder)
  );

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the SRT divider testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --assert --timescale 1ns/1ps \
  -f compile.f --top-module tbDivUnit -Mdir obj_dir -o simDivUnit

./obj_dir/simDivUnit | tee sim.log

if grep -q "^Testbench passed$" sim.log; then
  echo "Simulation result: PASS"
  exit 0
else
  echo "Simulation result: FAIL"
  exit 1
fi

// File: srtCtrl.sv
// Four-phase req/ack sequencer with operand capture and iteration counter
module srtCtrl (
  input  logic              clk,
  input  logic              arstN,
  input  logic              req,
  output logic              ack,
  input  divTypesPkg::dataT dividend,
  input  divTypesPkg::dataT divisor,
  input  logic              isSigned,
  output divTypesPkg::dataT opA,
  output divTypesPkg::dataT opB,
  output logic              opSigned,
  output logic              finish,
  srtIterIf.ctrl            iterBus
);

  divCtrlPkg::ctrlStateT state;
  divCtrlPkg::ctrlStateT stateNext;
  divTypesPkg::lzT       iterCnt;
  logic                  accept;
  logic                  lastIter;

  assign accept   = (state == divCtrlPkg::IDLE) && req;
  assign lastIter = (iterCnt == iterBus.numIter - divTypesPkg::lzT'(1));

  always_comb begin
    stateNext = state;
    case (state)
      divCtrlPkg::IDLE: if (req) stateNext = divCtrlPkg::LOAD;
      divCtrlPkg::LOAD: stateNext = divCtrlPkg::ITER;
      divCtrlPkg::ITER: if (lastIter) stateNext = divCtrlPkg::POST;
      divCtrlPkg::POST: stateNext = divCtrlPkg::ACK;
      // Hold the result until the requester lets go
      divCtrlPkg::ACK:  if (!req) stateNext = divCtrlPkg::IDLE;
      default:          stateNext = divCtrlPkg::IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state   <= divCtrlPkg::IDLE;
      iterCnt <= '0;
    end else begin
      state <= stateNext;
      if (state == divCtrlPkg::LOAD) begin
        iterCnt <= '0;
      end else if (state == divCtrlPkg::ITER) begin
        iterCnt <= iterCnt + divTypesPkg::lzT'(1);
      end
    end
  end

  // Operands stay put until the next accepted request
  always_ff @(posedge clk) begin
    if (accept) begin
      opA      <= dividend;
      opB      <= divisor;
      opSigned <= isSigned;
    end
  end

  assign iterBus.start = (state == divCtrlPkg::LOAD);
  assign finish        = (state == divCtrlPkg::POST);
  assign ack           = (state == divCtrlPkg::ACK);

  // Counter never runs past the digit count from preprocessing
  iterInRange: assert property (@(posedge clk) disable iff (!arstN)
    (state == divCtrlPkg::ITER) |-> (iterCnt < iterBus.numIter));

  // Requester keeps req up until the result is acknowledged
  reqHeldWhileBusy: assert property (@(posedge clk) disable iff (!arstN)
    (state == divCtrlPkg::LOAD || state == divCtrlPkg::ITER ||
     state == divCtrlPkg::POST) |-> req);

endmodule

// File: srtIterIf.sv
// Bundle between preprocessing, control, SRT recurrence and postprocessing
interface srtIterIf;

  // Normalized operands, fixed while a division runs
  divTypesPkg::wordT divWord;
  divTypesPkg::wordT dvdWord;
  divTypesPkg::lzT   numIter;
  // Remainder scaling, equal to the divisor leading-zero count
  divTypesPkg::lzT   remShift;

  // Load pulse for the recurrence registers
  logic              start;

  // Recurrence state after the last digit
  divTypesPkg::wordT remSum;
  divTypesPkg::wordT remCarry;
  divTypesPkg::dataT quot;
  divTypesPkg::dataT quotM;

  modport pre  (output divWord, dvdWord, numIter, remShift);
  modport ctrl (output start, input numIter);
  modport iter (input divWord, dvdWord, output remSum, remCarry, quot, quotM);
  modport post (input divWord, remShift, remSum, remCarry, quot, quotM);

endinterface

// File: srtIterate.sv
// Radix-2 SRT recurrence with carry-save remainder and on-the-fly quotient
module srtIterate (
  input  logic   clk,
  input  logic   arstN,
  input  logic   start,
  srtIterIf.iter iterBus
);

  localparam int W = divTypesPkg::WLEN;

  divTypesPkg::wordT ws;
  divTypesPkg::wordT wc;
  divTypesPkg::wordT dReg;
  divTypesPkg::wordT dSel;
  divTypesPkg::wordT csaSum;
  divTypesPkg::wordT csaCarry;
  divTypesPkg::dataT q;
  divTypesPkg::dataT qm;
  divTypesPkg::dataT qNext;
  divTypesPkg::dataT qmNext;
  logic [3:0]        est;
  logic              qp;
  logic              qz;
  logic              qn;

  ////////////////////////////////////////////////////////////////////////////
  // Digit selection
  ////////////////////////////////////////////////////////////////////////////

  // Integer part estimate of the shifted remainder
  assign est = ws[W-1:W-4] + wc[W-1:W-4];
  assign qp  = ~est[3];
  assign qz  = (est == 4'b1111);
  assign qn  = est[3] & ~qz;

  ////////////////////////////////////////////////////////////////////////////
  // Carry-save update
  ////////////////////////////////////////////////////////////////////////////

  // Subtract is complement plus carry-in at the free carry LSB
  assign dSel     = qp ? ~dReg : (qn ? dReg : '0);
  assign csaSum   = ws ^ wc ^ dSel;
  assign csaCarry = {(ws[W-2:0] & wc[W-2:0]) | (dSel[W-2:0] & (ws[W-2:0] | wc[W-2:0])), qp};

  // On-the-fly conversion keeps Q and Q-1 so digits never borrow
  always_comb begin
    if (qp) begin
      qNext  = {q[divTypesPkg::XLEN-2:0], 1'b1};
      qmNext = {q[divTypesPkg::XLEN-2:0], 1'b0};
    end else if (qz) begin
      qNext  = {q[divTypesPkg::XLEN-2:0], 1'b0};
      qmNext = {qm[divTypesPkg::XLEN-2:0], 1'b1};
    end else begin
      qNext  = {qm[divTypesPkg::XLEN-2:0], 1'b1};
      qmNext = {qm[divTypesPkg::XLEN-2:0], 1'b0};
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ws   <= '0;
      wc   <= '0;
      dReg <= '0;
      q    <= '0;
      qm   <= '0;
    end else if (start) begin
      ws   <= iterBus.dvdWord;
      wc   <= '0;
      dReg <= iterBus.divWord;
      q    <= '0;
      qm   <= '1;
    end else begin
      // Residual doubles each step
      ws <= {csaSum[W-2:0], 1'b0};
      wc <= {csaCarry[W-2:0], 1'b0};
      q  <= qNext;
      qm <= qmNext;
    end
  end

  assign iterBus.remSum   = ws;
  assign iterBus.remCarry = wc;
  assign iterBus.quot     = q;
  assign iterBus.quotM    = qm;

  // Estimate stays within -5 to 3 while a normalized divisor is loaded
  estInRange: assert property (@(posedge clk) disable iff (!arstN)
    (dReg != '0) |-> !(est inside {[4'd4 : 4'd10]}));

endmodule

// File: srtPostproc.sv
// Remainder resolution, correction, sign fix-up and result registers
module srtPostproc (
  input  logic              clk,
  input  logic              arstN,
  input  logic              finish,
  input  divTypesPkg::dataT opA,
  srtIterIf.post            iterBus,
  caseIf.dst                caseBus,
  output divTypesPkg::dataT quotient,
  output divTypesPkg::dataT remainder
);

  divTypesPkg::wordT sumW;
  divTypesPkg::wordT corrW;
  divTypesPkg::wordT remShifted;
  divTypesPkg::dataT quotMag;
  divTypesPkg::dataT remMag;
  divTypesPkg::dataT quotRes;
  divTypesPkg::dataT remRes;
  logic              remNeg;

  // Carry-propagate the redundant remainder
  assign sumW   = iterBus.remSum + iterBus.remCarry;
  assign remNeg = sumW[divTypesPkg::WLEN-1];

  // Stored residual is doubled so add back twice the divisor
  assign corrW = remNeg ? sumW + {iterBus.divWord[divTypesPkg::WLEN-2:0], 1'b0} : sumW;
  assign quotMag = remNeg ? iterBus.quotM : iterBus.quot;

  // Undo divisor normalization and fraction scaling
  assign remShifted = corrW >> (iterBus.remShift + divTypesPkg::lzT'(2));
  assign remMag     = remShifted[divTypesPkg::XLEN-1:0];

  always_comb begin
    quotRes = caseBus.negQuot ? -quotMag : quotMag;
    remRes  = caseBus.negRem ? -remMag : remMag;
    // Special cases win over the recurrence
    if (caseBus.divZero) begin
      quotRes = divCtrlPkg::DIVZERO_QUOT;
      remRes  = opA;
    end else if (caseBus.overflow) begin
      quotRes = divCtrlPkg::SIGNED_MIN;
      remRes  = '0;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      quotient  <= '0;
      remainder <= '0;
    end else if (finish) begin
      quotient  <= quotRes;
      remainder <= remRes;
    end
  end

endmodule

// File: srtPreproc.sv
// Operand normalization and iteration count for the SRT recurrence
module srtPreproc (
  input  divTypesPkg::dataT opA,
  input  divTypesPkg::dataT opB,
  input  logic              opSigned,
  srtIterIf.pre             iterBus
);

  divTypesPkg::dataT magA;
  divTypesPkg::dataT magB;
  divTypesPkg::lzT   lzA;
  divTypesPkg::lzT   lzB;
  divTypesPkg::lzT   dvdShift;
  divTypesPkg::dataT divNorm;
  divTypesPkg::dataT dvdNorm;

  // Leading zeros of a word, XLEN when the word is zero
  function automatic divTypesPkg::lzT lzCount(input divTypesPkg::dataT v);
    divTypesPkg::lzT cnt;
    logic            found;
    cnt   = divTypesPkg::lzT'(divTypesPkg::XLEN);
    found = 1'b0;
    for (int i = divTypesPkg::XLEN - 1; i >= 0; i--) begin
      if (!found && v[i]) begin
        cnt   = divTypesPkg::lzT'(divTypesPkg::XLEN - 1 - i);
        found = 1'b1;
      end
    end
    return cnt;
  endfunction

  // Magnitudes; signed minimum stays 2^31 read as unsigned
  assign magA = (opSigned && opA[divTypesPkg::XLEN-1]) ? -opA : opA;
  assign magB = (opSigned && opB[divTypesPkg::XLEN-1]) ? -opB : opB;

  assign lzA = lzCount(magA);
  assign lzB = lzCount(magB);

  // Dividend smaller than divisor is aligned to the divisor instead
  assign dvdShift = (lzA < lzB) ? lzA : lzB;

  assign divNorm = magB << lzB;
  assign dvdNorm = magA << dvdShift;

  // Leading one lands on the units bit, below sign and two guard bits
  assign iterBus.divWord = {3'b000, divNorm, 1'b0};
  assign iterBus.dvdWord = {3'b000, dvdNorm, 1'b0};

  // One digit per bit of quotient, never fewer than one
  assign iterBus.numIter  = lzB - dvdShift + divTypesPkg::lzT'(1);
  assign iterBus.remShift = lzB;

endmodule

// File: divVectors.svh
// Stimulus table, LFSR source and reference model, included inside the divider testbench

localparam int          NUM_RANDOM = 64;
localparam logic [15:0] LFSR_SEED  = 16'd76;

// Request operands and expected results, one entry per row
divTypesPkg::dataT tblDvd[$];
divTypesPkg::dataT tblDvs[$];
logic              tblSgn[$];
divTypesPkg::dataT tblQuot[$];
divTypesPkg::dataT tblRem[$];
logic [15:0]       lfsrState;

// Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsrNext(input logic [15:0] s);
  return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

// One LFSR step per bit, bits enter at the LSB
task automatic drawBits(input int n, output divTypesPkg::dataT v);
  v = '0;
  for (int i = 0; i < n; i++) begin
    lfsrState = lfsrNext(lfsrState);
    v = {v[divTypesPkg::XLEN-2:0], lfsrState[0]};
  end
endtask

// RISC-V rules: truncate toward zero, remainder keeps dividend sign
task automatic refDivide(input divTypesPkg::dataT a, input divTypesPkg::dataT b,
                         input logic s, output divTypesPkg::dataT q,
                         output divTypesPkg::dataT r);
  divTypesPkg::dataT magA;
  divTypesPkg::dataT magB;
  if (b == '0) begin
    q = '1;
    r = a;
  end else if (s && a == MIN_INT && b == '1) begin
    q = MIN_INT;
    r = '0;
  end else begin
    magA = (s && a[divTypesPkg::XLEN-1]) ? -a : a;
    magB = (s && b[divTypesPkg::XLEN-1]) ? -b : b;
    q = magA / magB;
    r = magA % magB;
    if (s && (a[divTypesPkg::XLEN-1] ^ b[divTypesPkg::XLEN-1])) q = -q;
    if (s && a[divTypesPkg::XLEN-1]) r = -r;
  end
endtask

// Append one request with its expected results
task automatic addRow(input divTypesPkg::dataT a, input divTypesPkg::dataT b, input logic s);
  divTypesPkg::dataT q;
  divTypesPkg::dataT r;
  refDivide(a, b, s, q, r);
  tblDvd.push_back(a);
  tblDvs.push_back(b);
  tblSgn.push_back(s);
  tblQuot.push_back(q);
  tblRem.push_back(r);
endtask

// File: tbDivUnit.sv
// Self-checking testbench for the SRT divider, run as the simulation top
module tbDivUnit;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 8;
  // Longest latency is about 37 cycles for a full 33-digit division
  localparam int ACK_TIMEOUT  = 60;
  localparam int NUM_FIXED    = 22;
  localparam divTypesPkg::dataT MIN_INT = {1'b1, {(divTypesPkg::XLEN - 1){1'b0}}};

`include "divVectors.svh"

  localparam int NUM_ROWS = NUM_FIXED + NUM_RANDOM;

  logic              clk;
  logic              arstN;
  logic              req;
  logic              ack;
  logic              isSigned;
  divTypesPkg::dataT dividend;
  divTypesPkg::dataT divisor;
  divTypesPkg::dataT quotient;
  divTypesPkg::dataT remainder;
  int                mismatchCount;
  int                protocolCount;
  logic              ackPrev;

  divUnit dut (
    .clk       (clk),
    .arstN     (arstN),
    .req       (req),
    .ack       (ack),
    .dividend  (dividend),
    .divisor   (divisor),
    .isSigned  (isSigned),
    .quotient  (quotient),
    .remainder (remainder)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Backstop of 50 cycles per row plus reset
  initial begin
    #((NUM_ROWS * 50 + RESET_CYCLES) * CLK_PERIOD);
    $display("Watchdog expired: the run did not complete in time");
    $display("Testbench failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Handshake monitor, sampled on the falling edge
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (arstN) begin
      // ack may only rise while a request is pending
      assert (!(ack && !ackPrev && !req)) else begin
        protocolCount++;
        $display("Protocol error at %0t: ack rose while req was low", $time);
      end
      // ack must hold until req is released
      assert (!(!ack && ackPrev && req)) else begin
        protocolCount++;
        $display("Protocol error at %0t: ack fell while req was still high", $time);
      end
    end
    ackPrev = ack;
  end

  // Fixed corner rows, then LFSR rows with varied magnitudes and signs
  task automatic buildTable();
    divTypesPkg::dataT rawA;
    divTypesPkg::dataT rawB;
    divTypesPkg::dataT shA;
    divTypesPkg::dataT shB;
    divTypesPkg::dataT flags;
    // Unsigned small, equal, large and dividend below divisor
    addRow(100, 7, 1'b0);
    addRow(7, 7, 1'b0);
    addRow(3, 10, 1'b0);
    addRow(0, 5, 1'b0);
    addRow(32'hFFFF_FFFF, 1, 1'b0);
    addRow(32'hFFFF_FFFF, 32'hFFFF_FFFF, 1'b0);
    addRow(32'h8000_0000, 3, 1'b0);
    addRow(12345678, 255, 1'b0);
    addRow(1, 32'hFFFF_FFFF, 1'b0);
    addRow(32'hDEAD_BEEF, 32'h0001_0000, 1'b0);
    // Signed, all four sign combinations
    addRow(100, 7, 1'b1);
    addRow(-100, 7, 1'b1);
    addRow(100, -7, 1'b1);
    addRow(-100, -7, 1'b1);
    addRow(-1, 2, 1'b1);
    addRow(32'h8000_0000, 1, 1'b1);
    addRow(32'h7FFF_FFFF, -1, 1'b1);
    // Division by zero
    addRow(1234, 0, 1'b0);
    addRow(-5, 0, 1'b1);
    addRow(0, 0, 1'b0);
    // Signed overflow and its unsigned twin
    addRow(32'h8000_0000, 32'hFFFF_FFFF, 1'b1);
    addRow(32'h8000_0000, 32'hFFFF_FFFF, 1'b0);
    lfsrState = LFSR_SEED;
    for (int k = 0; k < NUM_RANDOM; k++) begin
      drawBits(32, rawA);
      drawBits(32, rawB);
      drawBits(5, shA);
      drawBits(5, shB);
      drawBits(3, flags);
      rawA = rawA >> shA;
      rawB = rawB >> shB;
      // Random negation gives mixed signs in signed rows
      if (flags[0]) rawA = -rawA;
      if (flags[1]) rawB = -rawB;
      addRow(rawA, rawB, flags[2]);
    end
  endtask

  // Wait on falling edges until ack reaches a level
  task automatic waitAckLevel(input logic level);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (ack !== level && cycles < ACK_TIMEOUT);
    assert (ack === level) else begin
      protocolCount++;
      $display("Timeout at %0t: ack did not reach %0b within %0d cycles", $time, level,
               ACK_TIMEOUT);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // One four-phase transaction per table row
  ////////////////////////////////////////////////////////////////////////////

  task automatic runRow(input int i);
    divTypesPkg::dataT heldQ;
    divTypesPkg::dataT heldR;
    int                holdCycles;
    holdCycles = 1 + (i % 3);
    assert (!ack) else begin
      protocolCount++;
      $display("Protocol error: ack was already high before row %0d", i);
    end
    @(posedge clk);
    dividend <= tblDvd[i];
    divisor  <= tblDvs[i];
    isSigned <= tblSgn[i];
    req      <= 1'b1;
    waitAckLevel(1'b1);
    assert (quotient === tblQuot[i]) else begin
      mismatchCount++;
      $display("MISMATCH at %0t: row %0d sgn=%0b %h / %h quotient %h, expected %h", $time, i,
               tblSgn[i], tblDvd[i], tblDvs[i], quotient, tblQuot[i]);
    end
    assert (remainder === tblRem[i]) else begin
      mismatchCount++;
      $display("MISMATCH at %0t: row %0d sgn=%0b %h / %h remainder %h, expected %h", $time, i,
               tblSgn[i], tblDvd[i], tblDvs[i], remainder, tblRem[i]);
    end
    // Requester back-pressure, results must not move
    heldQ = quotient;
    heldR = remainder;
    repeat (holdCycles) begin
      @(negedge clk);
      assert (ack && quotient === heldQ && remainder === heldR) else begin
        protocolCount++;
        $display("Protocol error: ack or results changed while req was held on row %0d", i);
      end
    end
    @(posedge clk);
    req <= 1'b0;
    waitAckLevel(1'b0);
  endtask

  initial begin
    arstN         = 1'b0;
    req           = 1'b0;
    isSigned      = 1'b0;
    dividend      = '0;
    divisor       = '0;
    mismatchCount = 0;
    protocolCount = 0;
    ackPrev       = 1'b0;
    buildTable();
    repeat (RESET_CYCLES) @(posedge clk);
    arstN <= 1'b1;
    @(negedge clk);
    assert (!ack) else begin
      protocolCount++;
      $display("Protocol error: ack was high right after reset");
    end
    for (int i = 0; i < NUM_ROWS; i++) begin
      runRow(i);
    end
    repeat (2) @(negedge clk);
    $display("Summary: %0d rows, %0d mismatches, %0d protocol errors", NUM_ROWS,
             mismatchCount, protocolCount);
    if (mismatchCount == 0 && protocolCount == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
